// ==== Makefile ====
# Verilator build, run, lint and clean for the execute stage

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ex_stage_tb
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a failing exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_divider.sv
hw/ex_issue_reg.sv
hw/ex_result_sel.sv
hw/ex_stage.sv
dv/ex_stage_tb.sv

// ==== dv/ex_stage_tb.sv ====
// Table-driven testbench for the RISC-V execute stage with ALU, divider and CSR paths
`timescale 1ns/1ps

module ex_stage_tb;

    import ex_pkg::*;

    localparam int    CLK_PERIOD      = 40;
    localparam int    RST_CYCLES      = 16;
    localparam int    NUM_ENTRIES     = 25;
    // Worst case per entry is one full division plus issue and hold cycles
    localparam int    WATCHDOG_CYCLES = RST_CYCLES + NUM_ENTRIES * (DIV_STEPS + 8);
    localparam word_t PC_BASE         = 32'h0000_1000;

    // One stimulus row with its expected response
    typedef struct packed {
        alu_op_e     op;
        result_sel_e sel;
        logic        sgn;
        word_t       a;
        word_t       b;
        logic        br;
        word_t       target;
        logic        csr;
        word_t       rdata;
        logic        flush;
        logic        hold;
        word_t       exp_result;
        logic        exp_branch;
        logic        exp_trap;
        logic        exp_valid;
    } entry_t;

    entry_t      tbl [NUM_ENTRIES];
    integer      seed;

    // DUT inputs
    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    alu_op_e     alu_op_i;
    result_sel_e result_sel_i;
    logic        div_signed_i;
    word_t       operand_a_i;
    word_t       operand_b_i;
    reg_addr_t   rd_addr_i;
    logic        reg_wen_i;
    word_t       pc_i;
    logic        is_branch_i;
    word_t       branch_target_i;
    logic        csr_access_i;
    logic        stall_i;
    logic        flush_i;
    word_t       csr_rdata_i;
    logic        div_req_i;

    // DUT outputs
    logic        valid_o;
    reg_addr_t   rd_addr_o;
    logic        reg_wen_o;
    word_t       pc_o;
    word_t       branch_target_o;
    word_t       alu_result_o;
    logic        branch_decision_o;
    logic        trap_o;
    logic        csr_access_o;
    csr_addr_t   csr_addr_o;
    word_t       csr_wdata_o;
    logic        div_gnt_o;
    logic        div_busy_o;

    ex_stage UUT (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .valid_i           (valid_i),
        .alu_op_i          (alu_op_i),
        .result_sel_i      (result_sel_i),
        .div_signed_i      (div_signed_i),
        .operand_a_i       (operand_a_i),
        .operand_b_i       (operand_b_i),
        .rd_addr_i         (rd_addr_i),
        .reg_wen_i         (reg_wen_i),
        .pc_i              (pc_i),
        .is_branch_i       (is_branch_i),
        .branch_target_i   (branch_target_i),
        .csr_access_i      (csr_access_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .csr_rdata_i       (csr_rdata_i),
        .div_req_i         (div_req_i),
        .valid_o           (valid_o),
        .rd_addr_o         (rd_addr_o),
        .reg_wen_o         (reg_wen_o),
        .pc_o              (pc_o),
        .branch_target_o   (branch_target_o),
        .alu_result_o      (alu_result_o),
        .branch_decision_o (branch_decision_o),
        .trap_o            (trap_o),
        .csr_access_o      (csr_access_o),
        .csr_addr_o        (csr_addr_o),
        .csr_wdata_o       (csr_wdata_o),
        .div_gnt_o         (div_gnt_o),
        .div_busy_o        (div_busy_o)
    );

    ////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////

    // Integer ALU rules with 0 or 1 from compares
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0] shamt;
        shamt = b[4:0];
        case (op)
            ALU_ADD:           return a + b;
            ALU_SUB:           return a - b;
            ALU_AND:           return a & b;
            ALU_OR:            return a | b;
            ALU_XOR:           return a ^ b;
            ALU_SLL:           return a << shamt;
            ALU_SRL:           return a >> shamt;
            ALU_SRA:           return word_t'($signed(a) >>> shamt);
            ALU_SLT, ALU_LT:   return word_t'($signed(a) < $signed(b));
            ALU_SLTU, ALU_LTU: return word_t'(a < b);
            ALU_EQ:            return word_t'(a == b);
            ALU_NE:            return word_t'(a != b);
            ALU_GE:            return word_t'($signed(a) >= $signed(b));
            ALU_GEU:           return word_t'(a >= b);
            default:           return '0;
        endcase
    endfunction

    // RISC-V divide rules including divide by zero and signed overflow
    function automatic word_t div_ref(input logic want_rem, input logic sgn,
                                      input word_t a, input word_t b);
        word_t quo;
        word_t rem;
        if (b == '0) begin
            quo = '1;
            rem = a;
        end else if (sgn && (a == 32'h8000_0000) && (b == '1)) begin
            quo = a;
            rem = '0;
        end else if (sgn) begin
            quo = word_t'($signed(a) / $signed(b));
            rem = word_t'($signed(a) % $signed(b));
        end else begin
            quo = a / b;
            rem = a % b;
        end
        return want_rem ? rem : quo;
    endfunction

    function word_t next_rand();
        return word_t'($random(seed));
    endfunction

    ////////////////////////////////////////
    // Table setup
    ////////////////////////////////////////

    task automatic set_entry(input int idx, input alu_op_e op, input result_sel_e sel,
                             input logic sgn, input word_t a, input word_t b,
                             input logic br, input word_t target, input logic csr,
                             input word_t rdata, input logic flush, input logic hold);
        tbl[idx].op     = op;
        tbl[idx].sel    = sel;
        tbl[idx].sgn    = sgn;
        tbl[idx].a      = a;
        tbl[idx].b      = b;
        tbl[idx].br     = br;
        tbl[idx].target = target;
        tbl[idx].csr    = csr;
        tbl[idx].rdata  = rdata;
        tbl[idx].flush  = flush;
        tbl[idx].hold   = hold;
        if (flush) begin
            // Bubble keeps the payload of the row before it
            tbl[idx].exp_result = tbl[idx-1].exp_result;
            tbl[idx].exp_branch = 1'b0;
            tbl[idx].exp_trap   = 1'b0;
            tbl[idx].exp_valid  = 1'b0;
        end else begin
            if (csr) begin
                tbl[idx].exp_result = rdata;
            end else if (sel == RES_ALU) begin
                tbl[idx].exp_result = alu_ref(op, a, b);
            end else begin
                tbl[idx].exp_result = div_ref(sel == RES_REM, sgn, a, b);
            end
            tbl[idx].exp_branch = br && tbl[idx].exp_result[0];
            // Misaligned only matters without compressed instructions
            tbl[idx].exp_trap   = tbl[idx].exp_branch && target[1] && !COMPRESSED_EN;
            tbl[idx].exp_valid  = 1'b1;
        end
    endtask

    task automatic build_table();
        // ALU operations on random operands
        set_entry(0, ALU_ADD, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(1, ALU_SUB, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(2, ALU_AND, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(3, ALU_OR, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(4, ALU_XOR, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(5, ALU_SLL, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        // This one is also held under stall
        set_entry(6, ALU_SRL, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 1);
        set_entry(7, ALU_SRA, RES_ALU, 0, 32'h8000_00f0, 32'd4, 0, '0, 0, '0, 0, 0);
        set_entry(8, ALU_SLT, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(9, ALU_SLTU, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        // Flushed issue
        set_entry(10, ALU_ADD, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 0, '0, 1, 0);
        // Divide and remainder
        set_entry(11, ALU_ADD, RES_DIV, 1, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(12, ALU_ADD, RES_REM, 0, next_rand(), next_rand(), 0, '0, 0, '0, 0, 0);
        set_entry(13, ALU_ADD, RES_DIV, 1, 32'hffff_fff9, 32'd2, 0, '0, 0, '0, 0, 0);
        set_entry(14, ALU_ADD, RES_REM, 1, 32'hffff_fff9, 32'd2, 0, '0, 0, '0, 0, 0);
        set_entry(15, ALU_ADD, RES_DIV, 0, next_rand(), '0, 0, '0, 0, '0, 0, 0);
        set_entry(16, ALU_ADD, RES_REM, 1, next_rand(), '0, 0, '0, 0, '0, 0, 0);
        set_entry(17, ALU_ADD, RES_DIV, 1, 32'h8000_0000, '1, 0, '0, 0, '0, 0, 0);
        set_entry(18, ALU_ADD, RES_REM, 1, 32'h8000_0000, '1, 0, '0, 0, '0, 0, 0);
        // Branches to aligned and misaligned targets
        set_entry(19, ALU_EQ, RES_ALU, 0, 32'd5, 32'd5, 1, 32'h2000, 0, '0, 0, 0);
        set_entry(20, ALU_NE, RES_ALU, 0, 32'd1, 32'd1, 1, 32'h2002, 0, '0, 0, 0);
        set_entry(21, ALU_LT, RES_ALU, 0, '1, 32'd1, 1, 32'h2002, 0, '0, 0, 0);
        set_entry(22, ALU_GEU, RES_ALU, 0, next_rand(), next_rand(), 1, 32'h3006, 0, '0, 0, 0);
        // CSR read with write data and address capture
        set_entry(23, ALU_ADD, RES_ALU, 0, next_rand(), next_rand(), 0, '0, 1, 32'h5a5a_1234,
                  0, 0);
        set_entry(24, ALU_LTU, RES_ALU, 0, 32'd1, 32'd2, 0, '0, 0, '0, 0, 0);
    endtask

    ////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////

    task automatic check_value(input string name, input word_t exp_val, input word_t act_val);
        assert (act_val === exp_val) else begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Called right after a rising edge
    task automatic drive_entry(input int idx);
        valid_i         <= 1'b1;
        alu_op_i        <= tbl[idx].op;
        result_sel_i    <= tbl[idx].sel;
        div_signed_i    <= tbl[idx].sgn;
        operand_a_i     <= tbl[idx].a;
        operand_b_i     <= tbl[idx].b;
        rd_addr_i       <= reg_addr_t'(idx);
        reg_wen_i       <= 1'b1;
        pc_i            <= PC_BASE + word_t'(4 * idx);
        is_branch_i     <= tbl[idx].br;
        branch_target_i <= tbl[idx].target;
        csr_access_i    <= tbl[idx].csr;
        csr_rdata_i     <= tbl[idx].rdata;
        flush_i         <= tbl[idx].flush;
        stall_i         <= 1'b0;
        div_req_i       <= 1'b0;
    endtask

    task automatic check_outputs(input int idx);
        int src;
        // Flush leaves the payload of the previous row
        src = tbl[idx].flush ? idx - 1 : idx;
        check_value("valid_o", word_t'(tbl[idx].exp_valid), word_t'(valid_o));
        check_value("reg_wen_o", word_t'(tbl[idx].exp_valid), word_t'(reg_wen_o));
        check_value("alu_result_o", tbl[idx].exp_result, alu_result_o);
        check_value("branch_decision_o", word_t'(tbl[idx].exp_branch),
                    word_t'(branch_decision_o));
        check_value("trap_o", word_t'(tbl[idx].exp_trap), word_t'(trap_o));
        check_value("csr_access_o", word_t'(tbl[idx].csr && !tbl[idx].flush),
                    word_t'(csr_access_o));
        check_value("pc_o", PC_BASE + word_t'(4 * src), pc_o);
        check_value("rd_addr_o", word_t'(reg_addr_t'(src)), word_t'(rd_addr_o));
        check_value("branch_target_o", tbl[src].target, branch_target_o);
        if (tbl[idx].csr) begin
            check_value("csr_wdata_o", tbl[idx].a, csr_wdata_o);
            check_value("csr_addr_o", word_t'(tbl[idx].b[CSR_ADDR_W-1:0]), word_t'(csr_addr_o));
        end
    endtask

    // Strobe the divider with stall held and wait for busy to drop
    task automatic run_divide(input int idx);
        @(posedge clk_i);
        stall_i   <= 1'b1;
        div_req_i <= 1'b1;
        @(posedge clk_i);
        div_req_i <= 1'b0;
        @(negedge clk_i);
        check_value("div_busy_o", word_t'(1'b1), word_t'(div_busy_o));
        check_value("div_gnt_o", word_t'(1'b0), word_t'(div_gnt_o));
        while (div_busy_o) begin
            @(negedge clk_i);
        end
        check_value("div_gnt_o", word_t'(1'b1), word_t'(div_gnt_o));
        check_outputs(idx);
    endtask

    // Outputs must not move while stalled with changed decode inputs
    task automatic hold_and_check(input int idx);
        @(posedge clk_i);
        stall_i         <= 1'b1;
        valid_i         <= 1'b0;
        alu_op_i        <= ALU_ADD;
        operand_a_i     <= ~tbl[idx].a;
        operand_b_i     <= ~tbl[idx].b;
        rd_addr_i       <= ~reg_addr_t'(idx);
        reg_wen_i       <= 1'b0;
        pc_i            <= ~(PC_BASE + word_t'(4 * idx));
        is_branch_i     <= 1'b1;
        branch_target_i <= ~tbl[idx].target;
        csr_access_i    <= 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_outputs(idx);
    endtask

    ////////////////////////////////////////
    // Clock, watchdog and main sequence
    ////////////////////////////////////////

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the run timed out before the table finished");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

    initial begin
        seed            = 32'hf40ab6f4;
        rst_n_i         = 1'b0;
        valid_i         = 1'b0;
        alu_op_i        = ALU_ADD;
        result_sel_i    = RES_ALU;
        div_signed_i    = 1'b0;
        operand_a_i     = '0;
        operand_b_i     = '0;
        rd_addr_i       = '0;
        reg_wen_i       = 1'b0;
        pc_i            = '0;
        is_branch_i     = 1'b0;
        branch_target_i = '0;
        csr_access_i    = 1'b0;
        stall_i         = 1'b0;
        flush_i         = 1'b0;
        csr_rdata_i     = '0;
        div_req_i       = 1'b0;
        build_table();

        repeat (RST_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        // Idle state right after reset
        check_value("valid_o", '0, word_t'(valid_o));
        check_value("reg_wen_o", '0, word_t'(reg_wen_o));
        check_value("branch_decision_o", '0, word_t'(branch_decision_o));
        check_value("trap_o", '0, word_t'(trap_o));
        check_value("csr_access_o", '0, word_t'(csr_access_o));
        check_value("div_busy_o", '0, word_t'(div_busy_o));
        check_value("div_gnt_o", word_t'(1'b1), word_t'(div_gnt_o));

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk_i);
            drive_entry(i);
            if ((tbl[i].sel != RES_ALU) && !tbl[i].csr && !tbl[i].flush) begin
                run_divide(i);
            end else begin
                @(posedge clk_i);
                @(negedge clk_i);
                check_outputs(i);
                if (tbl[i].hold) begin
                    hold_and_check(i);
                end
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== hw/ex_alu.sv ====
// Single-cycle integer ALU for arithmetic, logic, shifts and compares
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::alu_op_e alu_op_i,
    input  ex_pkg::word_t   operand_a_i,
    input  ex_pkg::word_t   operand_b_i,
    output ex_pkg::word_t   result_o
);

    import ex_pkg::*;

    // Shift amount from the low bits of operand B
    logic [$clog2(XLEN)-1:0] shamt;
    // Shared compare terms
    logic                    is_eq;
    logic                    is_lt;
    logic                    is_ltu;

    assign shamt  = operand_b_i[$clog2(XLEN)-1:0];
    assign is_eq  = (operand_a_i == operand_b_i);
    assign is_lt  = ($signed(operand_a_i) < $signed(operand_b_i));
    assign is_ltu = (operand_a_i < operand_b_i);

    always_comb begin
        result_o = '0;
        unique case (alu_op_i)
            // Arithmetic
            ALU_ADD:  result_o = operand_a_i + operand_b_i;
            ALU_SUB:  result_o = operand_a_i - operand_b_i;
            // Bitwise logic
            ALU_AND:  result_o = operand_a_i & operand_b_i;
            ALU_OR:   result_o = operand_a_i | operand_b_i;
            ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
            // Shifts
            ALU_SLL:  result_o = operand_a_i << shamt;
            ALU_SRL:  result_o = operand_a_i >> shamt;
            ALU_SRA:  result_o = word_t'($signed(operand_a_i) >>> shamt);
            // Set-less-than for SLT/SLTU instructions
            ALU_SLT:  result_o = word_t'(is_lt);
            ALU_SLTU: result_o = word_t'(is_ltu);
            // Branch compares, result in bit 0
            ALU_EQ:   result_o = word_t'(is_eq);
            ALU_NE:   result_o = word_t'(!is_eq);
            ALU_LT:   result_o = word_t'(is_lt);
            ALU_GE:   result_o = word_t'(!is_lt);
            ALU_LTU:  result_o = word_t'(is_ltu);
            ALU_GEU:  result_o = word_t'(!is_ltu);
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== hw/ex_divider.sv ====
// Iterative restoring divider for DIV, DIVU, REM and REMU
`timescale 1ns/1ps

module ex_divider (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          req_i,
    input  logic          signed_i,
    input  ex_pkg::word_t dividend_i,
    input  ex_pkg::word_t divisor_i,
    output logic          gnt_o,
    output logic          busy_o,
    output ex_pkg::word_t quotient_o,
    output ex_pkg::word_t remainder_o
);

    import ex_pkg::*;

    div_state_e           state_q;
    logic [DIV_CNT_W-1:0] step_q;
    logic                 accept;

    // Operands taken at acceptance
    word_t                dividend_q;
    word_t                divisor_q;
    logic                 signed_q;

    // Working registers of the shift-subtract loop
    word_t                div_mag_q;
    word_t                quo_q;
    word_t                rem_q;

    // Datapath terms
    word_t                dividend_mag;
    word_t                divisor_mag;
    logic [XLEN:0]        shifted;
    logic [XLEN:0]        trial;
    logic                 div_zero;
    logic                 overflow;
    logic                 neg_quo;
    logic                 neg_rem;
    word_t                quo_fix;
    word_t                rem_fix;

    // Grant whenever idle, busy until the result lands
    assign gnt_o  = (state_q == DIV_IDLE);
    assign busy_o = (state_q != DIV_IDLE);
    assign accept = req_i && gnt_o;

    // Magnitudes for the signed case
    assign dividend_mag = (signed_q && dividend_q[XLEN-1]) ? -dividend_q : dividend_q;
    assign divisor_mag  = (signed_q && divisor_q[XLEN-1]) ? -divisor_q : divisor_q;

    // Bring in next dividend bit and try the subtraction
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign trial   = shifted - {1'b0, div_mag_q};

    ////////////////////////////////////////
    // Sign and special-case fix-up
    ////////////////////////////////////////

    assign div_zero = (divisor_q == '0);
    assign overflow = signed_q && (dividend_q == {1'b1, {(XLEN-1){1'b0}}}) &&
                      (divisor_q == '1);
    // Quotient negative when signs differ, remainder follows dividend
    assign neg_quo  = signed_q && (dividend_q[XLEN-1] ^ divisor_q[XLEN-1]);
    assign neg_rem  = signed_q && dividend_q[XLEN-1];

    always_comb begin
        if (div_zero) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        end else if (overflow) begin
            quo_fix = dividend_q;
            rem_fix = '0;
        end else begin
            quo_fix = neg_quo ? -quo_q : quo_q;
            rem_fix = neg_rem ? -rem_q : rem_q;
        end
    end

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    // Step 0 loads, steps 1 to DIV_STEPS iterate
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            unique case (state_q)
                DIV_IDLE: begin
                    if (accept) begin
                        state_q <= DIV_RUN;
                        step_q  <= '0;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == DIV_CNT_W'(DIV_STEPS)) begin
                        state_q <= DIV_FIXUP;
                    end
                end
                DIV_FIXUP: state_q <= DIV_IDLE;
                default:   state_q <= DIV_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dividend_q <= dividend_i;
            divisor_q  <= divisor_i;
            signed_q   <= signed_i;
        end
        if (state_q == DIV_RUN) begin
            if (step_q == '0) begin
                // Dividend magnitude shifts out as quotient bits shift in
                quo_q     <= dividend_mag;
                div_mag_q <= divisor_mag;
                rem_q     <= '0;
            end else begin
                quo_q <= {quo_q[XLEN-2:0], !trial[XLEN]};
                rem_q <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];  // restore on borrow
            end
        end
        // Results stay put until the next division finishes
        if (state_q == DIV_FIXUP) begin
            quotient_o  <= quo_fix;
            remainder_o <= rem_fix;
        end
    end

endmodule

// ==== hw/ex_issue_reg.sv ====
// Decode-to-execute pipeline register with stall hold and flush bubble
`timescale 1ns/1ps

module ex_issue_reg (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Pipeline control
    input  logic                stall_i,
    input  logic                flush_i,

    // Fields from decode
    input  logic                valid_i,
    input  ex_pkg::alu_op_e     alu_op_i,
    input  ex_pkg::result_sel_e result_sel_i,
    input  logic                div_signed_i,
    input  ex_pkg::word_t       operand_a_i,
    input  ex_pkg::word_t       operand_b_i,
    input  ex_pkg::reg_addr_t   rd_addr_i,
    input  logic                reg_wen_i,
    input  ex_pkg::word_t       pc_i,
    input  logic                is_branch_i,
    input  ex_pkg::word_t       branch_target_i,
    input  logic                csr_access_i,

    // Registered fields for execute
    output logic                valid_o,
    output ex_pkg::alu_op_e     alu_op_o,
    output ex_pkg::result_sel_e result_sel_o,
    output logic                div_signed_o,
    output ex_pkg::word_t       operand_a_o,
    output ex_pkg::word_t       operand_b_o,
    output ex_pkg::reg_addr_t   rd_addr_o,
    output logic                reg_wen_o,
    output ex_pkg::word_t       pc_o,
    output logic                is_branch_o,
    output ex_pkg::word_t       branch_target_o,
    output logic                csr_access_o,
    output ex_pkg::word_t       csr_wdata_o,
    output ex_pkg::csr_addr_t   csr_addr_o
);

    import ex_pkg::*;

    // New instruction enters only when neither stalled nor flushed
    logic load_en;

    assign load_en = !stall_i && !flush_i;

    ////////////////////////////////////////
    // Control fields
    ////////////////////////////////////////

    // Flush turns the slot into a bubble, stall keeps it as is
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o      <= 1'b0;
            reg_wen_o    <= 1'b0;
            is_branch_o  <= 1'b0;
            csr_access_o <= 1'b0;
        end else if (!stall_i) begin
            if (flush_i) begin
                valid_o      <= 1'b0;
                reg_wen_o    <= 1'b0;
                is_branch_o  <= 1'b0;
                csr_access_o <= 1'b0;
            end else begin
                valid_o      <= valid_i;
                reg_wen_o    <= reg_wen_i;
                is_branch_o  <= is_branch_i;
                csr_access_o <= csr_access_i;
            end
        end
    end

    ////////////////////////////////////////
    // Payload fields
    ////////////////////////////////////////

    // Payload keeps its old value across stall and flush
    always_ff @(posedge clk_i) begin
        if (load_en) begin
            alu_op_o        <= alu_op_i;
            result_sel_o    <= result_sel_i;
            div_signed_o    <= div_signed_i;
            operand_a_o     <= operand_a_i;
            operand_b_o     <= operand_b_i;
            rd_addr_o       <= rd_addr_i;
            pc_o            <= pc_i;
            branch_target_o <= branch_target_i;
        end
        // CSR write data rides on operand A, address on low bits of operand B
        if (load_en && csr_access_i) begin
            csr_wdata_o <= operand_a_i;
            csr_addr_o  <= operand_b_i[CSR_ADDR_W-1:0];
        end
    end

endmodule

// ==== hw/ex_pkg.sv ====
// Shared widths, types and constants of the RISC-V execute stage
package ex_pkg;

    ////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////

    // Integer data path width
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    // One divider iteration per quotient bit
    localparam int DIV_STEPS = XLEN;
    // Step counter spans the load step and all iterations
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

    // Compressed ISA off, so taken branch targets need word alignment
    localparam bit COMPRESSED_EN = 1'b0;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Integer ALU operations, compares give 0 or 1
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
        ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    // Source of the written-back value
    typedef enum logic [1:0] {
        RES_ALU,
        RES_DIV,
        RES_REM
    } result_sel_e;

    // Iterative divider control
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIXUP
    } div_state_e;

endpackage

// ==== hw/ex_result_sel.sv ====
// Result selection, CSR read pass-through, branch decision and trap
`timescale 1ns/1ps

module ex_result_sel (
    input  logic                valid_i,
    input  ex_pkg::result_sel_e result_sel_i,
    input  ex_pkg::word_t       alu_result_i,
    input  ex_pkg::word_t       quotient_i,
    input  ex_pkg::word_t       remainder_i,
    input  logic                csr_access_i,
    input  ex_pkg::word_t       csr_rdata_i,
    input  logic                is_branch_i,
    input  ex_pkg::word_t       branch_target_i,
    output ex_pkg::word_t       result_o,
    output logic                branch_decision_o,
    output logic                trap_o
);

    import ex_pkg::*;

    word_t exec_result;
    logic  target_misaligned;

    // Pick the functional unit output
    always_comb begin
        unique case (result_sel_i)
            RES_ALU: exec_result = alu_result_i;
            RES_DIV: exec_result = quotient_i;
            RES_REM: exec_result = remainder_i;
            default: exec_result = alu_result_i;
        endcase
    end

    // CSR reads return through the result path
    assign result_o = csr_access_i ? csr_rdata_i : exec_result;

    // Taken when the compare left a 1 in bit 0
    assign branch_decision_o = is_branch_i && result_o[0];

    ////////////////////////////////////////
    // Misaligned branch target trap
    ////////////////////////////////////////

    // Only word-aligned targets are legal without compressed instructions
    assign target_misaligned = !COMPRESSED_EN && branch_target_i[1] && branch_decision_o;

    assign trap_o = valid_i && target_misaligned;

endmodule

// ==== hw/ex_stage.sv ====
// Execute stage top joining issue register, ALU, divider and result select
`timescale 1ns/1ps

module ex_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // From decode
    input  logic                valid_i,
    input  ex_pkg::alu_op_e     alu_op_i,
    input  ex_pkg::result_sel_e result_sel_i,
    input  logic                div_signed_i,
    input  ex_pkg::word_t       operand_a_i,
    input  ex_pkg::word_t       operand_b_i,
    input  ex_pkg::reg_addr_t   rd_addr_i,
    input  logic                reg_wen_i,
    input  ex_pkg::word_t       pc_i,
    input  logic                is_branch_i,
    input  ex_pkg::word_t       branch_target_i,
    input  logic                csr_access_i,

    // From controller
    input  logic                stall_i,
    input  logic                flush_i,

    // From CSR file
    input  ex_pkg::word_t       csr_rdata_i,

    // Divider request strobe
    input  logic                div_req_i,

    // To writeback, fetch and CSR file
    output logic                valid_o,
    output ex_pkg::reg_addr_t   rd_addr_o,
    output logic                reg_wen_o,
    output ex_pkg::word_t       pc_o,
    output ex_pkg::word_t       branch_target_o,
    output ex_pkg::word_t       alu_result_o,
    output logic                branch_decision_o,
    output logic                trap_o,
    output logic                csr_access_o,
    output ex_pkg::csr_addr_t   csr_addr_o,
    output ex_pkg::word_t       csr_wdata_o,
    output logic                div_gnt_o,
    output logic                div_busy_o
);

    import ex_pkg::*;

    // Registered fields used only inside the stage
    alu_op_e     alu_op_q;
    result_sel_e result_sel_q;
    logic        div_signed_q;
    word_t       operand_a_q;
    word_t       operand_b_q;
    logic        is_branch_q;

    // Functional unit outputs
    word_t       alu_result;
    word_t       quotient;
    word_t       remainder;

    ex_issue_reg u_issue_reg (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .valid_i         (valid_i),
        .alu_op_i        (alu_op_i),
        .result_sel_i    (result_sel_i),
        .div_signed_i    (div_signed_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .rd_addr_i       (rd_addr_i),
        .reg_wen_i       (reg_wen_i),
        .pc_i            (pc_i),
        .is_branch_i     (is_branch_i),
        .branch_target_i (branch_target_i),
        .csr_access_i    (csr_access_i),
        .valid_o         (valid_o),
        .alu_op_o        (alu_op_q),
        .result_sel_o    (result_sel_q),
        .div_signed_o    (div_signed_q),
        .operand_a_o     (operand_a_q),
        .operand_b_o     (operand_b_q),
        .rd_addr_o       (rd_addr_o),
        .reg_wen_o       (reg_wen_o),
        .pc_o            (pc_o),
        .is_branch_o     (is_branch_q),
        .branch_target_o (branch_target_o),
        .csr_access_o    (csr_access_o),
        .csr_wdata_o     (csr_wdata_o),
        .csr_addr_o      (csr_addr_o)
    );

    ex_alu u_alu (
        .alu_op_i    (alu_op_q),
        .operand_a_i (operand_a_q),
        .operand_b_i (operand_b_q),
        .result_o    (alu_result)
    );

    // Divider works on the held operands while stall is up
    ex_divider u_divider (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (div_req_i),
        .signed_i    (div_signed_q),
        .dividend_i  (operand_a_q),
        .divisor_i   (operand_b_q),
        .gnt_o       (div_gnt_o),
        .busy_o      (div_busy_o),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    ex_result_sel u_result_sel (
        .valid_i           (valid_o),
        .result_sel_i      (result_sel_q),
        .alu_result_i      (alu_result),
        .quotient_i        (quotient),
        .remainder_i       (remainder),
        .csr_access_i      (csr_access_o),
        .csr_rdata_i       (csr_rdata_i),
        .is_branch_i       (is_branch_q),
        .branch_target_i   (branch_target_o),
        .result_o          (alu_result_o),
        .branch_decision_o (branch_decision_o),
        .trap_o            (trap_o)
    );

endmodule
